// File: src/pdp8_defs.svh
`ifndef PDP8_DEFS_SVH
`define PDP8_DEFS_SVH

// highest field with real memory behind it
`define MAX_FIELD 3'd1

// fields built into core_mem, addressed by the low field bit
`define RAM_FIELDS 2

// ma[0:8] of the auto-index locations 0010-0017
`define AUTO_INDEX_PAGE 9'o001

`endif

// File: src/pdp8_pkg.sv
package pdp8_pkg;

    // one clock per state
    typedef enum logic [4:0] {
        F0, FW, F1, F2, F3,     // fetch
        D0, DW, D1, D2, D3,     // defer
        E0, EW, E1, E2, E3,     // execute
        H0, HW, H1, H2, H3      // halted, panel cycles
    } major_state_t;

    typedef enum logic [0:2] {
        AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR
    } opcode_t;

    // memory reference layout
    typedef struct packed {
        opcode_t     opcode;
        logic        indirect;
        logic        page;      // 1 = current page
        logic [0:6]  offset;
    } mri_word_t;

    // operate group 1
    typedef struct packed {
        opcode_t     opcode;
        logic        group;     // 0 here
        logic        cla;
        logic        cll;
        logic        cma;
        logic        cml;
        logic [0:2]  rotate;    // rar, ral, bsw
        logic        iac;
    } opr1_word_t;

    // operate group 2, only hlt is acted on
    typedef struct packed {
        opcode_t     opcode;
        logic        group;     // 1 here
        logic        cla;
        logic        sma;
        logic        sza;
        logic        snl;
        logic        skip_sense;
        logic        osr;
        logic        hlt;
        logic        eae;       // set selects group 3
    } opr2_word_t;

    typedef union packed {
        mri_word_t   mri;
        opr1_word_t  grp1;
        opr2_word_t  grp2;
    } instr_word_t;

endpackage

// File: src/core_mem.sv
`timescale 1ns/100ps
`include "pdp8_defs.svh"

module core_mem (
    input  logic        clk,
    input  logic [0:12] addr,       // field bit then word address
    input  logic [0:11] din,
    input  logic        write_en,
    output logic [0:11] dout
);

    logic [0:11] mem [0:`RAM_FIELDS*4096-1];

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];  // old word on a write cycle
    end

endmodule

// File: src/mem_addr.sv
`timescale 1ns/100ps
`include "pdp8_defs.svh"

module mem_addr (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_pkg::major_state_t state,
    input  logic [0:11]            pc,
    input  logic [0:11]            ac,
    input  logic [0:11]            sr,
    input  logic                   sw,
    input  logic                   addr_loadd,
    input  logic                   depd,
    input  logic                   examd,
    input  logic [0:2]             if_field,
    input  logic [0:2]             df_field,
    output pdp8_pkg::instr_word_t  instruction,
    output logic [0:11]            ma,
    output logic [0:11]            mdout,
    output logic                   isz_skip
);
    import pdp8_pkg::*;

    logic [0:11] addr;
    logic [0:2]  ema;
    logic [0:11] mdin;
    logic        write_en;
    logic        field_ok;
    logic        data_indirect;
    logic        auto_index;
    logic        mem_we;
    logic [0:11] mem_dout;
    logic [0:11] rd_word;

    // indirect data operands come from the data field
    assign data_indirect = instruction.mri.indirect &&
        (instruction.mri.opcode inside {AND, TAD, ISZ, DCA});

    always_comb begin
        case (state)
            F0, FW:  addr = pc;
            default: addr = ma;
        endcase
        case (state)
            E0, EW, E1, E2, E3: ema = data_indirect ? df_field : if_field;
            default:            ema = if_field;
        endcase
    end

    assign field_ok   = (ema <= `MAX_FIELD);
    assign mem_we     = write_en && field_ok;   // missing field ignores writes
    assign rd_word    = field_ok ? mem_dout : 12'o0000;
    assign auto_index = (ma[0:8] == `AUTO_INDEX_PAGE);

    core_mem core_mem_i (
        .clk      (clk),
        .addr     ({ema[2], addr}),
        .din      (mdin),
        .write_en (mem_we),
        .dout     (mem_dout)
    );

    // data path registers
    always_ff @(posedge clk) begin
        case (state)
            FW, DW, EW, HW: mdout <= rd_word;
            default: ;
        endcase
        case (state)
            D1: mdin <= mdout + 12'o0001;   // auto-index pointer
            E1: begin
                case (instruction.mri.opcode)
                    ISZ:     mdin <= mdout + 12'o0001;
                    JMS:     mdin <= pc;    // return address
                    DCA:     mdin <= ac;
                    default: ;
                endcase
            end
            H1: mdin <= sr;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ma          <= 12'o0000;
            instruction <= 12'o7000;
            write_en    <= 1'b0;
            isz_skip    <= 1'b0;
        end else begin
            write_en <= 1'b0;
            case (state)
                F0: ma <= pc;   // keeps the page of this instruction
                FW: instruction <= rd_word;
                F3: begin
                    if (!(instruction.mri.opcode inside {IOT, OPR})) begin
                        ma <= {instruction.mri.page ? ma[0:4] : 5'b00000,
                               instruction.mri.offset};
                    end
                end
                D1: write_en <= auto_index;
                D2: begin
                    if (auto_index)
                        ma <= mdout + 12'o0001;
                    else
                        ma <= mdout;
                end
                E1: begin
                    case (instruction.mri.opcode)
                        ISZ: begin
                            write_en <= 1'b1;
                            isz_skip <= (mdout == 12'o7777);
                        end
                        JMS, DCA: write_en <= 1'b1;
                        default: ;
                    endcase
                end
                E3: isz_skip <= 1'b0;
                H1: begin
                    if (addr_loadd)
                        ma <= sw ? 12'o7777 : sr;
                    else if (depd)
                        write_en <= 1'b1;
                end
                H2: begin
                    if (depd || examd)
                        ma <= ma + 12'o0001;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: src/major_state.sv
`timescale 1ns/100ps

module major_state (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_pkg::instr_word_t  instruction,
    input  logic                   load_addr,
    input  logic                   deposit,
    input  logic                   examine,
    input  logic                   cont,
    output pdp8_pkg::major_state_t state,
    output logic                   addr_loadd,
    output logic                   depd,
    output logic                   examd,
    output logic                   run
);
    import pdp8_pkg::*;

    major_state_t next_state;
    logic         halt_req;
    logic         panel_req;

    assign halt_req = instruction.grp2.group && !instruction.grp2.eae &&
                      instruction.grp2.hlt;
    assign panel_req = load_addr || deposit || examine;
    assign run = !(state inside {H0, HW, H1, H2, H3});

    always_comb begin
        next_state = state;
        case (state)
            F0: next_state = FW;
            FW: next_state = F1;
            F1: next_state = F2;
            F2: next_state = F3;
            F3: begin
                case (instruction.mri.opcode)
                    OPR:     next_state = halt_req ? H0 : F0;
                    IOT:     next_state = F0;   // no devices
                    default: next_state = instruction.mri.indirect ? D0 : E0;
                endcase
            end
            D0: next_state = DW;
            DW: next_state = D1;
            D1: next_state = D2;
            D2: next_state = D3;
            D3: next_state = E0;
            E0: next_state = EW;
            EW: next_state = E1;
            E1: next_state = E2;
            E2: next_state = E3;
            E3: next_state = F0;
            H0: begin
                if (panel_req)
                    next_state = HW;
                else if (cont)
                    next_state = F0;
            end
            HW: next_state = H1;
            H1: next_state = H2;
            H2: next_state = H3;
            H3: next_state = H0;
            default: next_state = H0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= H0;
            addr_loadd <= 1'b0;
            depd       <= 1'b0;
            examd      <= 1'b0;
        end else begin
            state <= next_state;
            if (state == H0) begin
                // one request per panel cycle, load address first
                addr_loadd <= load_addr;
                depd       <= !load_addr && deposit;
                examd      <= !load_addr && !deposit && examine;
            end else if (state == H3) begin
                addr_loadd <= 1'b0;
                depd       <= 1'b0;
                examd      <= 1'b0;
            end
        end
    end

endmodule

// File: src/accum_pc.sv
`timescale 1ns/100ps

module accum_pc (
    input  logic                   clk,
    input  logic                   reset,
    input  pdp8_pkg::major_state_t state,
    input  pdp8_pkg::instr_word_t  instruction,
    input  logic [0:11]            ma,
    input  logic [0:11]            mdout,
    input  logic                   isz_skip,
    input  logic                   addr_loadd,
    output logic [0:11]            pc,
    output logic [0:11]            ac,
    output logic                   link
);
    import pdp8_pkg::*;

    logic [0:12] opr_lac;   // link:ac through the operate chain
    logic [0:12] tad_sum;

    always_comb begin
        opr_lac = {link, ac};
        if (instruction.grp1.cla)
            opr_lac[1:12] = 12'o0000;
        if (instruction.grp1.cll)
            opr_lac[0] = 1'b0;
        if (instruction.grp1.cma)
            opr_lac[1:12] = ~opr_lac[1:12];
        if (instruction.grp1.cml)
            opr_lac[0] = ~opr_lac[0];
        if (instruction.grp1.iac)
            opr_lac = opr_lac + 13'd1;
    end

    // carry out of ac complements link
    assign tad_sum = {link, ac} + {1'b0, mdout};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= 12'o0000;
            ac   <= 12'o0000;
            link <= 1'b0;
        end else begin
            case (state)
                F1: pc <= pc + 12'o0001;
                F3: begin
                    if (instruction.grp1.opcode == OPR && !instruction.grp1.group)
                        {link, ac} <= opr_lac;
                end
                E2: begin
                    case (instruction.mri.opcode)
                        AND:     ac <= ac & mdout;
                        TAD:     {link, ac} <= tad_sum;
                        DCA:     ac <= 12'o0000;
                        default: ;
                    endcase
                end
                E3: begin
                    case (instruction.mri.opcode)
                        JMP:     pc <= ma;
                        JMS:     pc <= ma + 12'o0001;   // past the stored return
                        default: if (isz_skip) pc <= pc + 12'o0001;
                    endcase
                end
                H3: if (addr_loadd) pc <= ma;   // cont starts here
                default: ;
            endcase
        end
    end

endmodule

// File: src/pdp8_core.sv
`timescale 1ns/100ps

module pdp8_core (
    input  logic        clk,
    input  logic        reset,
    input  logic [0:11] sr,
    input  logic        sw,
    input  logic        load_addr,
    input  logic        deposit,
    input  logic        examine,
    input  logic        cont,
    input  logic [0:2]  if_field,
    input  logic [0:2]  df_field,
    output logic [0:11] pc,
    output logic [0:11] ac,
    output logic        link,
    output logic [0:11] ma,
    output logic [0:11] mdout,
    output logic        run
);
    import pdp8_pkg::*;

    major_state_t state;
    instr_word_t  instruction;
    logic         addr_loadd;
    logic         depd;
    logic         examd;
    logic         isz_skip;

    mem_addr mem_addr_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .pc          (pc),
        .ac          (ac),
        .sr          (sr),
        .sw          (sw),
        .addr_loadd  (addr_loadd),
        .depd        (depd),
        .examd       (examd),
        .if_field    (if_field),
        .df_field    (df_field),
        .instruction (instruction),
        .ma          (ma),
        .mdout       (mdout),
        .isz_skip    (isz_skip)
    );

    major_state major_state_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .load_addr   (load_addr),
        .deposit     (deposit),
        .examine     (examine),
        .cont        (cont),
        .state       (state),
        .addr_loadd  (addr_loadd),
        .depd        (depd),
        .examd       (examd),
        .run         (run)
    );

    accum_pc accum_pc_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .instruction (instruction),
        .ma          (ma),
        .mdout       (mdout),
        .isz_skip    (isz_skip),
        .addr_loadd  (addr_loadd),
        .pc          (pc),
        .ac          (ac),
        .link        (link)
    );

endmodule

// File: verif/pdp8_core_tb.sv
`timescale 1ns/100ps
`include "pdp8_defs.svh"

module pdp8_core_tb;

    // programs run well under 13 x 10 cycles and each panel strobe takes about 6
    localparam int CYCLE_LIMIT = 20000;

    logic        clk;
    logic        reset;
    logic [0:11] sr;
    logic        sw;
    logic        load_addr;
    logic        deposit;
    logic        examine;
    logic        cont;
    logic [0:2]  if_field;
    logic [0:2]  df_field;
    logic [0:11] pc;
    logic [0:11] ac;
    logic        link;
    logic [0:11] ma;
    logic [0:11] mdout;
    logic        run;

    logic [0:11] model [0:`RAM_FIELDS*4096-1];  // indexed by field bit and address
    logic [0:2]  cur_if;
    logic [0:11] cur_ma;    // panel address as the model tracks it
    int          errors = 0;
    int          checks = 0;
    int          mark = 0;
    int          cycles = 0;
    int unsigned seed;

    pdp8_core pdp8_core_i (
        .clk       (clk),
        .reset     (reset),
        .sr        (sr),
        .sw        (sw),
        .load_addr (load_addr),
        .deposit   (deposit),
        .examine   (examine),
        .cont      (cont),
        .if_field  (if_field),
        .df_field  (df_field),
        .pc        (pc),
        .ac        (ac),
        .link      (link),
        .ma        (ma),
        .mdout     (mdout),
        .run       (run)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the core never halted", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input logic [0:11] got,
                              input logic [0:11] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s is %o, expected %o", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - mark);
        mark = errors;
    endtask

    // missing fields read as zero
    function automatic logic [0:11] expected_word(input logic [0:11] addr);
        if (cur_if > `MAX_FIELD)
            return 12'o0000;
        return model[{cur_if[2], addr}];
    endfunction

    task automatic set_fields(input logic [0:2] instr_field, input logic [0:2] data_field);
        @(posedge clk);
        if_field <= instr_field;
        df_field <= data_field;
        cur_if = instr_field;
        @(negedge clk);
    endtask

    task automatic load_address(input logic [0:11] addr, input logic use_sw);
        logic [0:11] exp;
        exp = use_sw ? 12'o7777 : addr;
        @(posedge clk);
        sr        <= addr;
        sw        <= use_sw;
        load_addr <= 1'b1;
        @(posedge clk);
        load_addr <= 1'b0;
        repeat (4) @(posedge clk);  // HW, H1, H2, H3
        sw <= 1'b0;
        @(negedge clk);
        check_word("ma", ma, exp);
        check_word("pc", pc, exp);
        cur_ma = exp;
    endtask

    task automatic deposit_word(input logic [0:11] data);
        logic [0:11] addr;
        addr = cur_ma;
        @(posedge clk);
        sr      <= data;
        deposit <= 1'b1;
        @(posedge clk);
        deposit <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (cur_if <= `MAX_FIELD)
            model[{cur_if[2], addr}] = data;
        check_word("ma", ma, addr + 12'o0001);
        cur_ma = addr + 12'o0001;
    endtask

    task automatic examine_word();
        logic [0:11] addr;
        addr = cur_ma;
        @(posedge clk);
        examine <= 1'b1;
        @(posedge clk);
        examine <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_word("mdout", mdout, expected_word(addr));
        check_word("ma", ma, addr + 12'o0001);
        cur_ma = addr + 12'o0001;
    endtask

    task automatic run_until_halt();
        @(posedge clk);
        cont <= 1'b1;
        @(posedge clk);
        cont <= 1'b0;
        @(negedge clk);
        assert (run) else begin
            $display("run did not rise after cont at %0t ns", $time);
            errors++;
        end
        while (run)
            @(negedge clk);
    endtask

    task automatic test_deposit_examine();
        load_address(12'o1000, 1'b0);
        for (int i = 0; i < 8; i++)
            deposit_word(12'($urandom));
        load_address(12'o1000, 1'b0);
        for (int i = 0; i < 8; i++)
            examine_word();
        report_test("deposit and examine");
    endtask

    task automatic test_load_address();
        load_address(12'o0000, 1'b1);   // switch forces 7777
        load_address(12'($urandom), 1'b0);
        report_test("load address");
    endtask

    task automatic test_program();
        logic [0:11] a;
        logic [0:11] b;
        logic [0:11] mask;
        logic [0:12] sum;
        a = 12'($urandom);
        b = 12'($urandom);
        mask = 12'($urandom);
        sum = {1'b0, a} + {1'b0, b};
        load_address(12'o0040, 1'b0);
        deposit_word(a);
        deposit_word(b);
        deposit_word(mask);
        load_address(12'o0200, 1'b0);
        deposit_word(12'o7300);     // cla cll
        deposit_word(12'o1040);     // tad 40
        deposit_word(12'o1041);
        deposit_word(12'o3043);     // dca 43
        deposit_word(12'o1040);
        deposit_word(12'o0042);     // and 42
        deposit_word(12'o3044);
        deposit_word(12'o7402);     // hlt
        load_address(12'o0200, 1'b0);
        run_until_halt();
        model[13'o0043] = sum[1:12];
        model[13'o0044] = a & mask;
        check_word("ac", ac, 12'o0000);
        check_word("link", {11'b0, link}, {11'b0, sum[0]});
        check_word("pc", pc, 12'o0210);
        load_address(12'o0043, 1'b0);
        examine_word();
        examine_word();
        report_test("tad/and/dca program");
    endtask

    task automatic test_skip_jump();
        logic [0:11] v;
        logic [0:11] ptr;
        v = 12'($urandom);
        if (v == 12'o7777)
            v = 12'o0000;
        ptr = 12'o0417;
        load_address(12'o0010, 1'b0);
        deposit_word(ptr);          // auto-index pointer
        load_address(12'o0050, 1'b0);
        deposit_word(12'o7777);
        deposit_word(v);
        load_address(12'o0060, 1'b0);
        deposit_word(12'o0000);     // jms return slot
        deposit_word(12'o5410);     // jmp i 10
        load_address(12'o0400, 1'b0);
        deposit_word(12'o2050);     // isz 50 skips the hlt
        deposit_word(12'o7402);
        deposit_word(12'o2051);     // isz 51 without a skip
        deposit_word(12'o4060);     // jms 60
        deposit_word(12'o7402);
        load_address(ptr + 12'o0001, 1'b0);
        deposit_word(12'o7402);
        load_address(12'o0400, 1'b0);
        run_until_halt();
        model[13'o0010] = ptr + 12'o0001;
        model[13'o0050] = 12'o0000;
        model[13'o0051] = v + 12'o0001;
        model[13'o0060] = 12'o0404;
        check_word("pc", pc, ptr + 12'o0002);
        load_address(12'o0010, 1'b0);
        examine_word();
        load_address(12'o0050, 1'b0);
        examine_word();
        examine_word();
        load_address(12'o0060, 1'b0);
        examine_word();
        report_test("isz/jms/jmp indirect");
    endtask

    task automatic test_fields();
        logic [0:11] w;
        w = 12'($urandom);
        if (w == 12'o0000)
            w = 12'o0001;
        load_address(12'o0100, 1'b0);
        deposit_word(12'($urandom));
        set_fields(3'd2, 3'd0);     // no memory in field 2
        load_address(12'o0100, 1'b0);
        deposit_word(~w);
        load_address(12'o0100, 1'b0);
        examine_word();
        set_fields(3'd1, 3'd0);
        load_address(12'o0300, 1'b0);
        deposit_word(12'o0000);
        set_fields(3'd0, 3'd0);
        load_address(12'o0100, 1'b0);
        examine_word();
        load_address(12'o0300, 1'b0);
        deposit_word(12'o0000);
        load_address(12'o0070, 1'b0);
        deposit_word(12'o0300);     // pointer
        deposit_word(w);
        load_address(12'o0600, 1'b0);
        deposit_word(12'o7200);     // cla
        deposit_word(12'o1071);     // tad 71
        deposit_word(12'o3470);     // dca i 70
        deposit_word(12'o7402);
        set_fields(3'd0, 3'd1);
        load_address(12'o0600, 1'b0);
        run_until_halt();
        model[13'o10300] = w;
        set_fields(3'd1, 3'd0);
        load_address(12'o0300, 1'b0);
        examine_word();
        set_fields(3'd0, 3'd0);
        load_address(12'o0300, 1'b0);
        examine_word();
        report_test("fields");
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        sr        = 12'o0000;
        sw        = 1'b0;
        load_addr = 1'b0;
        deposit   = 1'b0;
        examine   = 1'b0;
        cont      = 1'b0;
        if_field  = 3'd0;
        df_field  = 3'd0;
        cur_if    = 3'd0;
        cur_ma    = 12'o0000;
        seed = $urandom(32'hb9e3);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        test_deposit_examine();
        test_load_address();
        test_program();
        test_skip_jump();
        test_fields();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: pdp8_core.f
+incdir+src
src/pdp8_pkg.sv
src/core_mem.sv
src/mem_addr.sv
src/major_state.sv
src/accum_pc.sv
src/pdp8_core.sv
verif/pdp8_core_tb.sv
